// File: src/oppm_pkg.sv
package oppm_pkg;

  // Symbol and packet geometry
  localparam int SYM_W     = 2;
  localparam int PKT_W     = 8;
  localparam int DATA_SYMS = PKT_W / SYM_W;  // Data pulses per packet
  localparam int SLOTS     = 2 ** SYM_W;     // Slots per symbol

  // Slot length must fit in tick_t
  localparam int L_MAX = 15;

  // Receiver defaults
  localparam int L_DEF      = 8;
  localparam int DELTA_DEF  = 1;
  localparam int PRE_CT_DEF = 2;

  typedef logic [3:0]       tick_t;     // Tick within a slot
  typedef logic [SYM_W-1:0] sym_t;      // Slot index or symbol value
  typedef logic [PKT_W-1:0] pkt_t;
  typedef logic [2:0]       pre_ct_t;   // Preamble pulses seen
  typedef logic [2:0]       dsym_ct_t;  // Data symbols seen

  // Receive controller states
  typedef enum logic [1:0] {
    WAIT  = 2'd0,
    PREAM = 2'd1,
    DATA  = 2'd2,
    ERR   = 2'd3
  } rx_state_t;

endpackage

// File: src/oppm_slot_if.sv
`timescale 1ns/1ps

interface oppm_slot_if;
  import oppm_pkg::*;

  logic  run;              // Grid active
  tick_t tick_ct;
  sym_t  slot_idx;
  logic  near_begin;       // Within DELTA of a slot boundary
  sym_t  near_slot_idx;    // Slot being started
  logic  final_near_tick;
  logic  final_near_slot;

  modport timer (
    output run, tick_ct, slot_idx, near_begin, near_slot_idx,
    output final_near_tick, final_near_slot
  );

  modport monitor (
    input run, near_begin, final_near_tick, final_near_slot
  );

  // Controller and packet register
  modport sink (
    input near_slot_idx
  );

endinterface

// File: src/oppm_slot_timer.sv
`timescale 1ns/1ps

module oppm_slot_timer #(
  parameter int L     = oppm_pkg::L_DEF,
  parameter int DELTA = oppm_pkg::DELTA_DEF
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       grid_start,
  input  logic       grid_clear,
  oppm_slot_if.timer slot
);
  import oppm_pkg::*;

  // Window is only meaningful for DELTA < L/2
  localparam tick_t LAST_TICK  = tick_t'(L - 1);
  localparam tick_t BEGIN_TICK = tick_t'(DELTA);
  localparam tick_t END_TICK   = tick_t'(L - DELTA);
  localparam tick_t CHECK_TICK = tick_t'(L - 1 - DELTA);
  localparam sym_t  LAST_SLOT  = sym_t'(SLOTS - 1);

  logic  run_q;
  logic  run;
  tick_t tick_q;
  sym_t  slot_q;
  sym_t  next_slot;
  logic  final_tick;
  logic  final_slot;
  logic  at_begin;
  logic  at_end;

  assign run = run_q | grid_start;  // Counts from the start cycle itself

  // Stays up once started
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= run & ~grid_clear;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_q <= '0;
    end else if (!run || grid_clear) begin
      tick_q <= '0;  // Parked at 0 while idle
    end else if (final_tick) begin
      tick_q <= '0;
    end else begin
      tick_q <= tick_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= '0;
    end else if (!run || grid_clear) begin
      slot_q <= '0;
    end else if (final_tick) begin
      slot_q <= next_slot;
    end
  end

  always_comb begin
    final_tick = (tick_q == LAST_TICK);
    final_slot = (slot_q == LAST_SLOT);
    next_slot  = final_slot ? '0 : slot_q + 1'b1;

    at_begin = (tick_q <= BEGIN_TICK);
    at_end   = (tick_q >= END_TICK);   // Early edge for the next slot
  end

  assign slot.run             = run;
  assign slot.tick_ct         = tick_q;
  assign slot.slot_idx        = slot_q;
  assign slot.near_begin      = at_begin | at_end;
  assign slot.near_slot_idx   = at_end ? next_slot : slot_q;
  assign slot.final_near_tick = (tick_q == CHECK_TICK);
  assign slot.final_near_slot = (slot.near_slot_idx == LAST_SLOT);

endmodule

// File: src/oppm_pulse_monitor.sv
`timescale 1ns/1ps

module oppm_pulse_monitor (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         pulse,
  oppm_slot_if.monitor slot,
  output logic         edge_good,
  output logic         edge_bad,
  output logic         symbol_missed
);

  logic pulse_q;
  logic is_edge;
  logic check_pt;
  logic seen;  // Pulse seen in current symbol

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= pulse;
    end
  end

  assign is_edge = pulse & ~pulse_q;

  // Last tick before the next symbol's early window
  assign check_pt = slot.final_near_tick & slot.final_near_slot;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen <= 1'b0;
    end else if (!slot.run || check_pt) begin
      seen <= 1'b0;
    end else if (is_edge) begin
      seen <= 1'b1;
    end
  end

  always_comb begin
    // Idle grid parks the tick at 0, so a first edge is always in window
    edge_good     = is_edge & slot.near_begin;
    edge_bad      = is_edge & ~slot.near_begin;
    symbol_missed = check_pt & ~seen;  // Check point only reached while running
  end

endmodule

// File: src/oppm_packet_reg.sv
`timescale 1ns/1ps

module oppm_packet_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           reload,
  input  logic           shift,
  oppm_slot_if.sink      slot,
  output oppm_pkg::pkt_t data
);
  import oppm_pkg::*;

  pkt_t base;  // Value to shift from

  // Reload with shift starts a fresh packet from the new symbol
  assign base = reload ? '0 : data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data <= '0;
    end else if (shift) begin
      data <= {base[PKT_W-SYM_W-1:0], slot.near_slot_idx};  // MSB first
    end else begin
      data <= base;
    end
  end

endmodule

// File: src/oppm_rx_ctrl.sv
`timescale 1ns/1ps

module oppm_rx_ctrl #(
  parameter int PRE_CT = oppm_pkg::PRE_CT_DEF
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      edge_good,
  input  logic      edge_bad,
  input  logic      symbol_missed,
  input  logic      read,
  oppm_slot_if.sink slot,
  output logic      grid_start,
  output logic      grid_clear,
  output logic      reload,
  output logic      shift,
  output logic      avail,
  output logic      error
);
  import oppm_pkg::*;

  localparam pre_ct_t  PRE_LAST  = pre_ct_t'(PRE_CT);
  localparam dsym_ct_t DSYM_LAST = dsym_ct_t'(DATA_SYMS - 1);

  rx_state_t state;
  rx_state_t next_state;
  pre_ct_t   pre_ct;
  pre_ct_t   pre_ct_d;
  dsym_ct_t  dsym_ct;
  dsym_ct_t  dsym_ct_d;
  logic      pkt_done;     // Last data symbol accepted
  logic      fault;        // Stray, misplaced or missing pulse
  logic      flag_release;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= WAIT;
      pre_ct  <= '0;
      dsym_ct <= '0;
    end else begin
      state   <= next_state;
      pre_ct  <= pre_ct_d;
      dsym_ct <= dsym_ct_d;
    end
  end

  always_comb begin
    next_state = state;
    pre_ct_d   = pre_ct;
    dsym_ct_d  = dsym_ct;
    grid_start = 1'b0;
    grid_clear = 1'b0;
    reload     = 1'b0;
    shift      = 1'b0;
    pkt_done   = 1'b0;
    fault      = 1'b0;

    unique case (state)
      WAIT: begin
        pre_ct_d  = '0;
        dsym_ct_d = '0;
        if (edge_good) begin
          // First edge is preamble pulse 1 and slot 0 of the grid
          grid_start = 1'b1;
          pre_ct_d   = pre_ct_t'(1);
          next_state = (PRE_LAST == pre_ct_t'(1)) ? DATA : PREAM;
        end else begin
          grid_clear = 1'b1;
        end
      end

      PREAM: begin
        if (edge_bad || symbol_missed) begin
          fault = 1'b1;
        end else if (edge_good) begin
          if (slot.near_slot_idx != '0) begin
            fault = 1'b1;  // Preamble pulse off slot 0
          end else begin
            pre_ct_d = pre_ct + 1'b1;
            if (pre_ct_d == PRE_LAST) begin
              next_state = DATA;
            end
          end
        end
      end

      DATA: begin
        if (edge_bad || symbol_missed) begin
          fault = 1'b1;
        end else if (edge_good) begin
          shift  = 1'b1;
          reload = (dsym_ct == '0);  // Old packet kept until now
          if (dsym_ct == DSYM_LAST) begin
            pkt_done   = 1'b1;
            grid_clear = 1'b1;
            next_state = WAIT;
          end else begin
            dsym_ct_d = dsym_ct + 1'b1;
          end
        end
      end

      ERR: begin
        // One quiet cycle, grid held cleared
        grid_clear = 1'b1;
        pre_ct_d   = '0;
        dsym_ct_d  = '0;
        next_state = WAIT;
      end
    endcase

    if (fault) begin
      grid_clear = 1'b1;
      next_state = ERR;
    end
  end

  // Reader handshake, also released by a new incoming packet
  assign flag_release = read | grid_start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avail <= 1'b0;
      error <= 1'b0;
    end else begin
      avail <= pkt_done | (avail & ~flag_release);
      error <= fault | (error & ~flag_release);
    end
  end

endmodule

// File: src/oppm_rx_top.sv
`timescale 1ns/1ps

module oppm_rx_top #(
  parameter int L      = oppm_pkg::L_DEF,
  parameter int DELTA  = oppm_pkg::DELTA_DEF,
  parameter int PRE_CT = oppm_pkg::PRE_CT_DEF
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           pulse,
  input  logic           read,
  output oppm_pkg::pkt_t data,
  output logic           avail,
  output logic           error
);

  logic grid_start;
  logic grid_clear;
  logic edge_good;
  logic edge_bad;
  logic symbol_missed;
  logic shift;
  logic reload;

  oppm_slot_if slot_bus ();  // Slot grid position

  oppm_slot_timer #(.L(L), .DELTA(DELTA)) timer0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .grid_start (grid_start),
    .grid_clear (grid_clear),
    .slot       (slot_bus.timer)
  );

  oppm_pulse_monitor monitor0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .pulse         (pulse),
    .slot          (slot_bus.monitor),
    .edge_good     (edge_good),
    .edge_bad      (edge_bad),
    .symbol_missed (symbol_missed)
  );

  oppm_packet_reg pkt_reg0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .reload (reload),
    .shift  (shift),
    .slot   (slot_bus.sink),
    .data   (data)
  );

  oppm_rx_ctrl #(.PRE_CT(PRE_CT)) ctrl0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .edge_good     (edge_good),
    .edge_bad      (edge_bad),
    .symbol_missed (symbol_missed),
    .read          (read),
    .slot          (slot_bus.sink),
    .grid_start    (grid_start),
    .grid_clear    (grid_clear),
    .reload        (reload),
    .shift         (shift),
    .avail         (avail),
    .error         (error)
  );

endmodule

// File: dv/oppm_rx_sva.sv
`timescale 1ns/1ps

module oppm_rx_sva (
  input logic                clk,
  input logic                rst_n,
  input oppm_pkg::rx_state_t state,
  input logic                read,
  input logic                grid_start,
  input logic                shift,
  input logic                avail,
  input logic                error
);
  import oppm_pkg::*;

  // One outcome per packet
  a_one_flag: assert property (@(posedge clk) disable iff (!rst_n)
    !(avail && error))
    else $error("avail and error high together");

  // Flags held until read or a new first edge
  a_avail_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(avail) |-> ($past(read) || $past(grid_start)))
    else $error("avail dropped without read or grid_start");

  a_error_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(error) |-> ($past(read) || $past(grid_start)))
    else $error("error dropped without read or grid_start");

  a_shift_data: assert property (@(posedge clk) disable iff (!rst_n)
    shift |-> (state == DATA))
    else $error("shift outside DATA");

  a_start_wait: assert property (@(posedge clk) disable iff (!rst_n)
    grid_start |-> (state == WAIT))
    else $error("grid_start outside WAIT");

endmodule

bind oppm_rx_ctrl oppm_rx_sva sva0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .state      (state),
  .read       (read),
  .grid_start (grid_start),
  .shift      (shift),
  .avail      (avail),
  .error      (error)
);

// File: dv/oppm_rx_tb.sv
`timescale 1ns/1ps

module oppm_rx_tb;
  import oppm_pkg::*;

  localparam int L       = L_DEF;
  localparam int DELTA   = DELTA_DEF;
  localparam int PRE_CT  = PRE_CT_DEF;
  localparam int SYM_LEN = SLOTS * L;  // Cycles per symbol
  localparam int TIMEOUT = (PRE_CT + DATA_SYMS + 2) * SYM_LEN;

  logic clk;
  logic rst_n;
  logic pulse;
  logic read;
  pkt_t data;
  logic avail;
  logic error;

  int edge_at[$];  // Edge offsets in cycles from the first pulse

  oppm_rx_top #(.L(L), .DELTA(DELTA), .PRE_CT(PRE_CT)) dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .pulse (pulse),
    .read  (read),
    .data  (data),
    .avail (avail),
    .error (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop in case a loop bound is wrong
  initial begin
    #200_000;
    $display("Simulation time limit reached before the test finished");
    $display("** FAIL **");
    $fatal(1, "Time limit");
  end

  task automatic check_pkt(input string name, input pkt_t exp, input pkt_t act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "Packet mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "Flag mismatch");
    end
  endtask

  function automatic int jitter();
    return int'($urandom_range(2 * DELTA)) - DELTA;
  endfunction

  function automatic void add_pulse(input int sym_n, input int slot_n, input int offset);
    edge_at.push_back((sym_n * SLOTS + slot_n) * L + offset);
  endfunction

  // First edge defines the grid, later preamble pulses jitter
  function automatic void add_preamble();
    add_pulse(0, 0, 0);
    for (int p = 1; p < PRE_CT; p++) begin
      add_pulse(p, 0, jitter());
    end
  endfunction

  function automatic bit pulse_high(input int n);
    foreach (edge_at[i]) begin
      if (n == edge_at[i] || n == edge_at[i] + 1) return 1'b1;  // 2 cycles high
    end
    return 1'b0;
  endfunction

  // Plays the queued edges, then empties the queue
  task automatic drive_train();
    int last;
    last = edge_at[$];
    for (int n = 0; n <= last + 2; n++) begin
      @(negedge clk);
      if (n == 1) begin
        check_flag("avail", 1'b0, avail);  // Released by the first edge
        check_flag("error", 1'b0, error);
      end
      pulse = pulse_high(n) ? 1'b1 : 1'b0;
    end
    edge_at.delete();
  endtask

  task automatic wait_decision();
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      if (avail || error) break;
      @(negedge clk);
    end
    if (!(avail || error)) begin
      $display("Timeout waiting for avail or error after a pulse train");
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  endtask

  task automatic do_read();
    read = 1'b1;
    @(negedge clk);
    read = 1'b0;
    check_flag("avail", 1'b0, avail);
    check_flag("error", 1'b0, error);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  // Random symbols, expected packet built MSB first
  task automatic send_clean(output pkt_t exp);
    sym_t s;
    exp = '0;
    add_preamble();
    for (int d = 0; d < DATA_SYMS; d++) begin
      s = sym_t'($urandom_range(SLOTS - 1));
      add_pulse(PRE_CT + d, int'(s), jitter());
      exp[PKT_W - 1 - d * SYM_W -: SYM_W] = s;
    end
    drive_train();
  endtask

  task automatic expect_packet(input pkt_t exp);
    wait_decision();
    check_flag("avail", 1'b1, avail);
    check_flag("error", 1'b0, error);
    check_pkt("data", exp, data);
  endtask

  task automatic expect_error();
    wait_decision();
    check_flag("error", 1'b1, error);
    check_flag("avail", 1'b0, avail);
    do_read();
  endtask

  // Preamble plus n random clean data pulses
  function automatic void add_clean_head(input int n);
    add_preamble();
    for (int d = 0; d < n; d++) begin
      add_pulse(PRE_CT + d, int'($urandom_range(SLOTS - 1)), jitter());
    end
  endfunction

  initial begin
    pkt_t exp;
    int   n_data;
    void'($urandom(71911));
    rst_n = 1'b0;
    pulse = 1'b0;
    read  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_flag("avail", 1'b0, avail);
    check_flag("error", 1'b0, error);
    check_pkt("data", '0, data);

    repeat (8) begin
      send_clean(exp);
      expect_packet(exp);
      do_read();
      idle(2 * SYM_LEN);
    end

    // Second preamble pulse off slot 0
    repeat (3) begin
      add_pulse(0, 0, 0);
      add_pulse(1, 1 + int'($urandom_range(SLOTS - 2)), jitter());
      drive_train();
      expect_error();
      idle(2 * SYM_LEN);
    end

    // Data edge outside the window
    repeat (4) begin
      n_data = int'($urandom_range(DATA_SYMS - 1));
      add_clean_head(n_data);
      add_pulse(PRE_CT + n_data, int'($urandom_range(SLOTS - 1)),
                DELTA + 1 + int'($urandom_range(L - 2 * DELTA - 2)));
      drive_train();
      expect_error();
      idle(2 * SYM_LEN);
    end

    // Missing data pulse, then a clean packet
    repeat (3) begin
      n_data = int'($urandom_range(DATA_SYMS - 1));
      add_clean_head(n_data);
      drive_train();
      expect_error();
      idle(2 * SYM_LEN);
      send_clean(exp);
      expect_packet(exp);
      do_read();
      idle(2 * SYM_LEN);
    end

    // Back-pressure, no read between two packets
    send_clean(exp);
    expect_packet(exp);
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      check_flag("avail", 1'b1, avail);
      check_flag("error", 1'b0, error);
    end
    send_clean(exp);
    expect_packet(exp);
    do_read();
    idle(SYM_LEN);

    $display("** PASS **");
    $finish;
  end

endmodule

// File: verilog.f
src/oppm_pkg.sv
src/oppm_slot_if.sv
src/oppm_slot_timer.sv
src/oppm_pulse_monitor.sv
src/oppm_packet_reg.sv
src/oppm_rx_ctrl.sv
src/oppm_rx_top.sv
dv/oppm_rx_sva.sv
dv/oppm_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= oppm_rx_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
